// ==== include/rv_decode_defines.svh ====
/* rv32i decode constants */
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define EXU_OPT_W   5
`define EXU_SEL_W   3   // five select codes need 3 bits
`define LSU_OPT_W   4

// major opcodes
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_IMM      7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_REG      7'b0110011

// alu func3, shared by reg and imm groups
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// branch func3
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

// access size func3, loads and stores alike
`define F3_B        3'b000
`define F3_H        3'b001
`define F3_W        3'b010
`define F3_BU       3'b100
`define F3_HU       3'b101

`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000

`endif

// ==== source/rv_decode_pkg.sv ====
/* rv32i decode types */
`include "rv_decode_defines.svh"

package rv_decode_pkg;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_view_s;

    typedef struct packed {
        logic [19:0]            imm_u;  // inst[31:12]
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } u_view_s;

    typedef union packed {
        r_view_s r_view;
        u_view_s u_view;
    } inst_u;

    typedef enum logic [2:0] {
        FMT_NONE, FMT_R, FMT_I, FMT_ISH, FMT_S, FMT_B, FMT_U, FMT_J
    } fmt_e;

    typedef enum logic [`EXU_OPT_W-1:0] {
        EXU_NOP, EXU_ADD, EXU_SUB, EXU_AND, EXU_OR, EXU_XOR,
        EXU_SLL_R, EXU_SRL_R, EXU_SRA_R, EXU_SLL_I, EXU_SRL_I, EXU_SRA_I,
        EXU_COMPARE, EXU_COMPARE_U,
        EXU_BEQ, EXU_BNE, EXU_BLT, EXU_BGE, EXU_BLTU, EXU_BGEU
    } exu_opt_e;

    typedef enum logic [`EXU_SEL_W-1:0] {
        SEL_NONE, SEL_RS1_AND_IMM, SEL_PC_AND_IMM, SEL_PC_AND_4, SEL_RS1_AND_RS2
    } exu_sel_e;

    typedef enum logic [`LSU_OPT_W-1:0] {
        LSU_NOP, LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU, LSU_SB, LSU_SH, LSU_SW
    } lsu_opt_e;

    typedef struct packed {
        logic     wr_en_rd;
        logic     jal_jump_en;
        logic     jalr_jump_en;
        logic     branch_en;
        exu_opt_e exu_opt;
        exu_sel_e exu_sel;
        lsu_opt_e lsu_opt;
    } ctrl_s;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] addr_rd;
        logic [`REG_ADDR_W-1:0] addr_rs1;
        logic [`REG_ADDR_W-1:0] addr_rs2;
        logic [`XLEN-1:0]       imm;
    } operand_s;

    typedef struct packed {
        ctrl_s    ctrl;
        operand_s opnd;
    } dec_s;

endpackage

// ==== source/opcode_ctrl.sv ====
/* opcode and funct decode */
`include "rv_decode_defines.svh"

module opcode_ctrl import rv_decode_pkg::*; (
    input  inst_u inst,
    output ctrl_s ctrl,
    output fmt_e  fmt
);

    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;

    assign op = inst.r_view.opcode;
    assign f3 = inst.r_view.funct3;
    assign f7 = inst.r_view.funct7;

    always_comb begin
        ctrl = '0;  // lsu_opt falls to LSU_NOP
        fmt  = FMT_NONE;
        case (op)
            `OP_LUI: begin
                ctrl.exu_opt = EXU_ADD;  // x0 + imm
                ctrl.exu_sel = SEL_RS1_AND_IMM;
                fmt          = FMT_U;
            end
            `OP_AUIPC: begin
                ctrl.exu_opt = EXU_ADD;
                ctrl.exu_sel = SEL_PC_AND_IMM;
                fmt          = FMT_U;
            end
            `OP_JAL: begin
                ctrl.jal_jump_en = 1'b1;
                ctrl.exu_opt     = EXU_ADD;  // link value pc + 4
                ctrl.exu_sel     = SEL_PC_AND_4;
                fmt              = FMT_J;
            end
            `OP_JALR: begin
                ctrl.jalr_jump_en = 1'b1;
                ctrl.exu_opt      = EXU_ADD;
                ctrl.exu_sel      = SEL_PC_AND_4;
                fmt               = FMT_I;
            end
            `OP_IMM: begin
                case (f3)
                    `F3_ADD:  ctrl.exu_opt = EXU_ADD;
                    `F3_SLT:  ctrl.exu_opt = EXU_COMPARE;
                    `F3_SLTU: ctrl.exu_opt = EXU_COMPARE_U;
                    `F3_XOR:  ctrl.exu_opt = EXU_XOR;
                    `F3_OR:   ctrl.exu_opt = EXU_OR;
                    `F3_AND:  ctrl.exu_opt = EXU_AND;
                    `F3_SLL: begin
                        if (f7 == `F7_BASE) ctrl.exu_opt = EXU_SLL_I;
                    end
                    `F3_SR: begin
                        if (f7 == `F7_BASE) ctrl.exu_opt = EXU_SRL_I;
                        else if (f7 == `F7_ALT) ctrl.exu_opt = EXU_SRA_I;
                    end
                    default: ;
                endcase
                if (ctrl.exu_opt != EXU_NOP) begin
                    ctrl.exu_sel = SEL_RS1_AND_IMM;
                    fmt = (f3 == `F3_SLL || f3 == `F3_SR) ? FMT_ISH : FMT_I;
                end
            end
            `OP_LOAD: begin
                case (f3)
                    `F3_B:   ctrl.lsu_opt = LSU_LB;
                    `F3_H:   ctrl.lsu_opt = LSU_LH;
                    `F3_W:   ctrl.lsu_opt = LSU_LW;
                    `F3_BU:  ctrl.lsu_opt = LSU_LBU;
                    `F3_HU:  ctrl.lsu_opt = LSU_LHU;
                    default: ;
                endcase
                if (ctrl.lsu_opt != LSU_NOP) begin
                    ctrl.exu_opt = EXU_ADD;  // address rs1 + imm
                    ctrl.exu_sel = SEL_RS1_AND_IMM;
                    fmt          = FMT_I;
                end
            end
            `OP_STORE: begin
                case (f3)
                    `F3_B:   ctrl.lsu_opt = LSU_SB;
                    `F3_H:   ctrl.lsu_opt = LSU_SH;
                    `F3_W:   ctrl.lsu_opt = LSU_SW;
                    default: ;
                endcase
                if (ctrl.lsu_opt != LSU_NOP) begin
                    ctrl.exu_opt = EXU_ADD;
                    ctrl.exu_sel = SEL_RS1_AND_IMM;
                    fmt          = FMT_S;
                end
            end
            `OP_BRANCH: begin
                case (f3)
                    `F3_BEQ:  ctrl.exu_opt = EXU_BEQ;
                    `F3_BNE:  ctrl.exu_opt = EXU_BNE;
                    `F3_BLT:  ctrl.exu_opt = EXU_BLT;
                    `F3_BGE:  ctrl.exu_opt = EXU_BGE;
                    `F3_BLTU: ctrl.exu_opt = EXU_BLTU;
                    `F3_BGEU: ctrl.exu_opt = EXU_BGEU;
                    default: ;
                endcase
                if (ctrl.exu_opt != EXU_NOP) begin
                    ctrl.branch_en = 1'b1;
                    ctrl.exu_sel   = SEL_RS1_AND_RS2;
                    fmt            = FMT_B;
                end
            end
            `OP_REG: begin
                if (f7 == `F7_BASE) begin
                    case (f3)
                        `F3_ADD:  ctrl.exu_opt = EXU_ADD;
                        `F3_SLL:  ctrl.exu_opt = EXU_SLL_R;
                        `F3_SLT:  ctrl.exu_opt = EXU_COMPARE;
                        `F3_SLTU: ctrl.exu_opt = EXU_COMPARE_U;
                        `F3_XOR:  ctrl.exu_opt = EXU_XOR;
                        `F3_SR:   ctrl.exu_opt = EXU_SRL_R;
                        `F3_OR:   ctrl.exu_opt = EXU_OR;
                        `F3_AND:  ctrl.exu_opt = EXU_AND;
                        default: ;
                    endcase
                end else if (f7 == `F7_ALT) begin
                    if (f3 == `F3_ADD) ctrl.exu_opt = EXU_SUB;
                    else if (f3 == `F3_SR) ctrl.exu_opt = EXU_SRA_R;
                end
                if (ctrl.exu_opt != EXU_NOP) begin  // m extension lands here as nop
                    ctrl.exu_sel = SEL_RS1_AND_RS2;
                    fmt          = FMT_R;
                end
            end
            default: ;
        endcase
        // every format with an rd field writes it back
        ctrl.wr_en_rd = fmt inside {FMT_R, FMT_I, FMT_ISH, FMT_U, FMT_J};
    end

endmodule

// ==== source/operand_gen.sv ====
/* register fields and immediate */
module operand_gen import rv_decode_pkg::*; (
    input  inst_u    inst,
    input  fmt_e     fmt,
    output operand_s opnd
);

    r_view_s r;
    logic    sgn;

    assign r   = inst.r_view;
    assign sgn = r.funct7[6];  // inst[31]

    always_comb begin
        opnd = '0;
        case (fmt)
            FMT_I:   opnd.imm = {{20{sgn}}, r.funct7, r.rs2};
            FMT_ISH: opnd.imm = {27'b0, r.rs2};  // shamt, zero-extended
            FMT_S:   opnd.imm = {{20{sgn}}, r.funct7, r.rd};
            FMT_B:   opnd.imm = {{20{sgn}}, r.rd[0], r.funct7[5:0], r.rd[4:1], 1'b0};
            FMT_U:   opnd.imm = {inst.u_view.imm_u, 12'b0};
            FMT_J: begin
                opnd.imm = {{12{sgn}}, inst.u_view.imm_u[7:0], inst.u_view.imm_u[8],
                            inst.u_view.imm_u[18:9], 1'b0};
            end
            default: ;
        endcase

        if (fmt inside {FMT_R, FMT_I, FMT_ISH, FMT_U, FMT_J}) opnd.addr_rd = r.rd;
        // u format has no rs1, so lui reads x0
        if (fmt inside {FMT_R, FMT_I, FMT_ISH, FMT_S, FMT_B}) opnd.addr_rs1 = r.rs1;
        if (fmt inside {FMT_R, FMT_S, FMT_B}) opnd.addr_rs2 = r.rs2;
    end

endmodule

// ==== source/decode_reg.sv ====
/* decode output register */
module decode_reg import rv_decode_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     inst_valid,
    input  ctrl_s    ctrl,
    input  operand_s opnd,
    output logic     dec_valid,
    output dec_s     dec
);

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
            dec       <= '0;
        end else begin
            dec_valid <= inst_valid;  // one-cycle strobe follows input
            if (inst_valid) begin
                dec.ctrl <= ctrl;
                dec.opnd <= opnd;
            end
        end
    end

endmodule

// ==== source/rv_decode_top.sv ====
/* rv32i decode stage */
module rv_decode_top import rv_decode_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  inst_valid,
    input  inst_u inst,
    output logic  dec_valid,
    output dec_s  dec
);

    ctrl_s    ctrl;
    fmt_e     fmt;
    operand_s opnd;

    opcode_ctrl i_opcode_ctrl (
        .inst (inst),
        .ctrl (ctrl),
        .fmt  (fmt)
    );

    operand_gen i_operand_gen (
        .inst (inst),
        .fmt  (fmt),
        .opnd (opnd)
    );

    decode_reg i_decode_reg (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .ctrl       (ctrl),
        .opnd       (opnd),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

endmodule

// ==== tests/rv_decode_sva.sv ====
/* decode stage assertions */
module rv_decode_sva import rv_decode_pkg::*; (
    input logic clk,
    input logic rst,
    input logic inst_valid,
    input logic dec_valid,
    input dec_s dec
);
    timeunit 1ns;
    timeprecision 100ps;

    a_valid_follows: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> dec_valid == $past(inst_valid))
        else $error("dec_valid differs from the previous cycle's inst_valid");

    // jal, jalr and branch are mutually exclusive
    a_one_transfer: assert property (@(posedge clk) disable iff (rst)
        $onehot0({dec.ctrl.jal_jump_en, dec.ctrl.jalr_jump_en, dec.ctrl.branch_en}))
        else $error("more than one control transfer flag is set");

    a_reset_clears: assert property (@(posedge clk) $past(rst) |-> !dec_valid)
        else $error("dec_valid is high in the cycle after reset");

endmodule

bind rv_decode_top rv_decode_sva i_rv_decode_sva (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .dec_valid  (dec_valid),
    .dec        (dec)
);

// ==== tests/rv_decode_checker.sv ====
/* decode reference checker */
`include "rv_decode_defines.svh"

module rv_decode_checker import rv_decode_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  inst_valid,
    input  inst_u inst,
    input  logic  dec_valid,
    input  dec_s  dec,
    output int    checks,
    output int    data_errs,
    output int    valid_errs,
    output logic  busy
);
    timeunit 1ns;
    timeprecision 100ps;

    int          n_checks     = 0;
    int          n_data_errs  = 0;
    int          n_valid_errs = 0;
    logic        have_prev    = 1'b0;
    logic        prev_rst;
    logic        prev_valid   = 1'b0;
    logic [31:0] prev_inst;
    dec_s        exp_dec      = '0;  // model of the output register
    string       exp_name     = "reset";

    assign checks     = n_checks;
    assign data_errs  = n_data_errs;
    assign valid_errs = n_valid_errs;
    assign busy       = prev_valid;

    // reference decode from the rv32i encoding rules
    function automatic dec_s model_decode(input logic [31:0] w, output string name);
        dec_s       d;
        fmt_e       f;
        logic [6:0] f7;
        logic [2:0] f3;
        d    = '0;
        f    = FMT_NONE;
        f7   = w[31:25];
        f3   = w[14:12];
        name = "unknown";
        case (w[6:0])
            `OP_LUI: begin
                name = "lui";
                f    = FMT_U;
                d.ctrl.exu_opt = EXU_ADD;
                d.ctrl.exu_sel = SEL_RS1_AND_IMM;
            end
            `OP_AUIPC: begin
                name = "auipc";
                f    = FMT_U;
                d.ctrl.exu_opt = EXU_ADD;
                d.ctrl.exu_sel = SEL_PC_AND_IMM;
            end
            `OP_JAL: begin
                name = "jal";
                f    = FMT_J;
                d.ctrl.jal_jump_en = 1'b1;
                d.ctrl.exu_opt     = EXU_ADD;
                d.ctrl.exu_sel     = SEL_PC_AND_4;
            end
            `OP_JALR: begin
                name = "jalr";
                f    = FMT_I;
                d.ctrl.jalr_jump_en = 1'b1;
                d.ctrl.exu_opt      = EXU_ADD;
                d.ctrl.exu_sel      = SEL_PC_AND_4;
            end
            `OP_LOAD: begin
                name = "load";
                f    = FMT_I;
                d.ctrl.exu_opt = EXU_ADD;
                d.ctrl.exu_sel = SEL_RS1_AND_IMM;
                case (f3)
                    `F3_B:   d.ctrl.lsu_opt = LSU_LB;
                    `F3_H:   d.ctrl.lsu_opt = LSU_LH;
                    `F3_W:   d.ctrl.lsu_opt = LSU_LW;
                    `F3_BU:  d.ctrl.lsu_opt = LSU_LBU;
                    `F3_HU:  d.ctrl.lsu_opt = LSU_LHU;
                    default: f = FMT_NONE;
                endcase
            end
            `OP_STORE: begin
                name = "store";
                f    = FMT_S;
                d.ctrl.exu_opt = EXU_ADD;
                d.ctrl.exu_sel = SEL_RS1_AND_IMM;
                case (f3)
                    `F3_B:   d.ctrl.lsu_opt = LSU_SB;
                    `F3_H:   d.ctrl.lsu_opt = LSU_SH;
                    `F3_W:   d.ctrl.lsu_opt = LSU_SW;
                    default: f = FMT_NONE;
                endcase
            end
            `OP_BRANCH: begin
                name = "branch";
                f    = FMT_B;
                d.ctrl.branch_en = 1'b1;
                d.ctrl.exu_sel   = SEL_RS1_AND_RS2;
                case (f3)
                    `F3_BEQ:  d.ctrl.exu_opt = EXU_BEQ;
                    `F3_BNE:  d.ctrl.exu_opt = EXU_BNE;
                    `F3_BLT:  d.ctrl.exu_opt = EXU_BLT;
                    `F3_BGE:  d.ctrl.exu_opt = EXU_BGE;
                    `F3_BLTU: d.ctrl.exu_opt = EXU_BLTU;
                    `F3_BGEU: d.ctrl.exu_opt = EXU_BGEU;
                    default:  f = FMT_NONE;
                endcase
            end
            `OP_IMM: begin
                name = "alu_imm";
                f    = FMT_I;
                d.ctrl.exu_sel = SEL_RS1_AND_IMM;
                case (f3)
                    `F3_ADD:  d.ctrl.exu_opt = EXU_ADD;
                    `F3_SLT:  d.ctrl.exu_opt = EXU_COMPARE;
                    `F3_SLTU: d.ctrl.exu_opt = EXU_COMPARE_U;
                    `F3_XOR:  d.ctrl.exu_opt = EXU_XOR;
                    `F3_OR:   d.ctrl.exu_opt = EXU_OR;
                    `F3_AND:  d.ctrl.exu_opt = EXU_AND;
                    `F3_SLL: begin
                        name = "shift_imm";
                        f    = (f7 == `F7_BASE) ? FMT_ISH : FMT_NONE;
                        d.ctrl.exu_opt = EXU_SLL_I;
                    end
                    `F3_SR: begin
                        name = "shift_imm";
                        f    = FMT_ISH;
                        if (f7 == `F7_BASE) d.ctrl.exu_opt = EXU_SRL_I;
                        else if (f7 == `F7_ALT) d.ctrl.exu_opt = EXU_SRA_I;
                        else f = FMT_NONE;
                    end
                    default: f = FMT_NONE;
                endcase
            end
            `OP_REG: begin
                name = "alu_reg";
                f    = FMT_R;
                d.ctrl.exu_sel = SEL_RS1_AND_RS2;
                case ({f7, f3})
                    {`F7_BASE, `F3_ADD}:  d.ctrl.exu_opt = EXU_ADD;
                    {`F7_BASE, `F3_SLL}:  d.ctrl.exu_opt = EXU_SLL_R;
                    {`F7_BASE, `F3_SLT}:  d.ctrl.exu_opt = EXU_COMPARE;
                    {`F7_BASE, `F3_SLTU}: d.ctrl.exu_opt = EXU_COMPARE_U;
                    {`F7_BASE, `F3_XOR}:  d.ctrl.exu_opt = EXU_XOR;
                    {`F7_BASE, `F3_SR}:   d.ctrl.exu_opt = EXU_SRL_R;
                    {`F7_BASE, `F3_OR}:   d.ctrl.exu_opt = EXU_OR;
                    {`F7_BASE, `F3_AND}:  d.ctrl.exu_opt = EXU_AND;
                    {`F7_ALT, `F3_ADD}:   d.ctrl.exu_opt = EXU_SUB;
                    {`F7_ALT, `F3_SR}:    d.ctrl.exu_opt = EXU_SRA_R;
                    default:              f = FMT_NONE;
                endcase
            end
            default: ;
        endcase

        if (f == FMT_NONE) begin
            name = "unknown";
            return '0;
        end

        d.ctrl.wr_en_rd = !(f inside {FMT_S, FMT_B});
        if (!(f inside {FMT_S, FMT_B})) d.opnd.addr_rd = w[11:7];
        if (!(f inside {FMT_U, FMT_J})) d.opnd.addr_rs1 = w[19:15];
        if (f inside {FMT_R, FMT_S, FMT_B}) d.opnd.addr_rs2 = w[24:20];
        case (f)
            FMT_I:   d.opnd.imm = {{21{w[31]}}, w[30:20]};
            FMT_ISH: d.opnd.imm = {27'd0, w[24:20]};
            FMT_S:   d.opnd.imm = {{21{w[31]}}, w[30:25], w[11:7]};
            FMT_B:   d.opnd.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            FMT_U:   d.opnd.imm = {w[31:12], 12'd0};
            FMT_J:   d.opnd.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: ;  // r format has no immediate
        endcase
        return d;
    endfunction

    // dut inputs and outputs are both settled at the falling edge
    always @(negedge clk) begin
        if (have_prev) begin
            if (prev_rst) begin
                exp_dec  = '0;
                exp_name = "reset";
            end else if (prev_valid) begin
                exp_dec = model_decode(prev_inst, exp_name);
            end else begin
                exp_name = "hold";
            end
            n_checks++;
            if (dec_valid !== (prev_valid && !prev_rst)) begin
                n_valid_errs++;
                $display("[FAIL] %s dec_valid: expected %b actual %b",
                         exp_name, prev_valid && !prev_rst, dec_valid);
            end
            if (dec !== exp_dec) begin
                n_data_errs++;
                $display("[FAIL] %s inst %h: expected %h actual %h",
                         exp_name, prev_inst, exp_dec, dec);
            end
        end
        have_prev  = 1'b1;
        prev_rst   = (rst !== 1'b0);  // unknown reset at start counts as reset
        prev_valid = inst_valid;
        prev_inst  = inst;
    end

endmodule

// ==== tests/tb_rv_decode.sv ====
/* rv32i decode stage testbench */
`include "rv_decode_defines.svh"

module tb_rv_decode import rv_decode_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CYCLES  = 3000;
    localparam int DRAIN_LIMIT = 20;

    logic        clk;
    logic        rst;
    logic        inst_valid;
    inst_u       inst;
    logic        dec_valid;
    dec_s        dec;
    int          checks;
    int          data_errs;
    int          valid_errs;
    logic        busy;
    logic [31:0] lfsr_state;
    logic        timed_out;
    int          wait_cnt;
    int          cycle_idx;

    rv_decode_top i_rv_decode_top (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

    rv_decode_checker i_rv_decode_checker (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .checks     (checks),
        .data_errs  (data_errs),
        .valid_errs (valid_errs),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    // random fields with an opcode class laid over them
    function automatic logic [31:0] make_inst();
        logic [31:0] w;
        logic [3:0]  kind;
        w = take_bits(32);
        if (take_bits(3) == 0) return w;  // raw word that is mostly unrecognized
        kind = 4'(take_bits(4));
        case (kind)
            4'd0:  w[6:0] = `OP_LUI;
            4'd1:  w[6:0] = `OP_AUIPC;
            4'd2:  w[6:0] = `OP_JAL;
            4'd3:  w[6:0] = `OP_JALR;
            4'd4, 4'd5: begin
                w[6:0] = `OP_IMM;
                if (w[14:12] == `F3_SLL) w[31:25] = `F7_BASE;
                if (w[14:12] == `F3_SR) w[31:25] = (take_bits(1) != 0) ? `F7_ALT : `F7_BASE;
            end
            4'd6:  w[6:0] = `OP_LOAD;  // f3 3, 6, 7 stay illegal
            4'd7: begin
                w[6:0] = `OP_STORE;
                w[14]  = 1'b0;  // f3 0..3
            end
            4'd8, 4'd9: w[6:0] = `OP_BRANCH;
            4'd10, 4'd11, 4'd12: begin
                w[6:0]   = `OP_REG;
                w[31:25] = (take_bits(1) != 0) ? `F7_ALT : `F7_BASE;
            end
            4'd13: begin
                w[6:0]   = `OP_REG;
                w[31:25] = 7'b0000001;  // m extension
            end
            4'd14: w[6:0] = 7'b1110011;  // system opcode
            default: w[6:0] = `OP_IMM;  // shift funct7 left random
        endcase
        return w;
    endfunction

    initial begin
        lfsr_state = 32'h595d;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        timed_out  = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        for (cycle_idx = 0; cycle_idx < NUM_CYCLES; cycle_idx++) begin
            inst_valid = take_bits(2) != 0;
            inst       = make_inst();
            @(posedge clk);
            #1;
        end
        inst_valid = 1'b0;

        // let the last word reach the checker and the strobe drop
        wait_cnt = 0;
        while ((busy !== 1'b0 || dec_valid !== 1'b0) && wait_cnt < DRAIN_LIMIT) begin
            @(negedge clk);
            #1;
            wait_cnt++;
        end
        if (busy !== 1'b0 || dec_valid !== 1'b0) begin
            timed_out = 1'b1;
            $display("timeout: decode output did not go idle after the last word");
        end
        if (checks == 0) $display("no decoded output was compared");

        $display("checks %0d, data errors %0d, valid errors %0d",
                 checks, data_errs, valid_errs);
        if (!timed_out && checks > 0 && data_errs == 0 && valid_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
source/rv_decode_pkg.sv
source/opcode_ctrl.sv
source/operand_gen.sv
source/decode_reg.sv
source/rv_decode_top.sv
tests/rv_decode_sva.sv
tests/rv_decode_checker.sv
tests/tb_rv_decode.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_decode
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test OK
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
